// File: Makefile
# Verilator build and run for the dual-link receive buffer.
# Any variable below can be overridden on the command line, e.g. make test TOP=...

VERILATOR ?= verilator
TOP       ?= tb_dual_link_rx
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= test passed

SIM_BIN = $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# The run passes only if the pass line shows up in the simulator output.
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
src/lane_pkg.sv
src/blk_fifo_if.sv
src/net_fifo_buf.sv
src/block_merger.sv
src/dual_link_rx.sv
testbench/tb_dual_link_rx.sv

// File: src/blk_fifo_if.sv
`timescale 1ns/1ps

interface blk_fifo_if #(
    parameter int DEPTH = 5
);
    import lane_pkg::*;

    logic           rd;       // Pop strobe from the merger.
    logic           empty;
    logic           full;
    data_t          data;     // Show-ahead oldest entry.
    ctrl_t          ctrl;
    logic [DEPTH:0] space;    // Free entries.

    modport fifo (
        input  rd,
        output empty,
        output full,
        output data,
        output ctrl,
        output space
    );

    modport merger (
        output rd,
        input  empty,
        input  full,
        input  data,
        input  ctrl,
        input  space
    );

endinterface

// File: src/block_merger.sv
`timescale 1ns/1ps

module block_merger (
    input  logic              clk,
    input  logic              reset,
    blk_fifo_if.merger        lane0,
    blk_fifo_if.merger        lane1,
    output logic              out_valid,
    output lane_pkg::lane_t   out_lane,
    output lane_pkg::data_t   out_data,
    output lane_pkg::ctrl_t   out_ctrl,
    output lane_pkg::count_t  bad_count
);
    import lane_pkg::*;

    localparam lane_t LANE0 = 1'b0;
    localparam lane_t LANE1 = 1'b1;

    lane_t  prio;       // Lane that wins a tie.
    lane_t  sel;
    logic   pop;
    data_t  pop_data;
    ctrl_t  pop_ctrl;
    logic   hdr_ok;

    // Pick one non-empty lane per cycle.
    always_comb begin
        pop = ~lane0.empty | ~lane1.empty;
        if (!lane0.empty && !lane1.empty) begin
            sel = prio;
        end else if (!lane0.empty) begin
            sel = LANE0;
        end else begin
            sel = LANE1;
        end
    end

    assign lane0.rd = pop & (sel == LANE0);
    assign lane1.rd = pop & (sel == LANE1);

    // Block at the head of the chosen lane.
    always_comb begin
        if (sel == LANE1) begin
            pop_data = lane1.data;
            pop_ctrl = lane1.ctrl;
        end else begin
            pop_data = lane0.data;
            pop_ctrl = lane0.ctrl;
        end
    end

    assign hdr_ok = (pop_ctrl == SYNC_DATA) || (pop_ctrl == SYNC_CTRL);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio <= LANE0;
        end else if (pop) begin
            prio <= ~sel;   // Other lane goes first next time.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop & hdr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && hdr_ok) begin
            out_lane <= sel;
            out_data <= pop_data;
            out_ctrl <= pop_ctrl;
        end
    end

    // Saturating count of dropped blocks.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bad_count <= '0;
        end else if (pop && !hdr_ok && (bad_count != '1)) begin
            bad_count <= bad_count + 1'b1;
        end
    end

endmodule

// File: src/dual_link_rx.sv
`timescale 1ns/1ps

module dual_link_rx #(
    parameter int DEPTH = 5
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr0,
    input  logic              wr1,
    input  lane_pkg::data_t   data0,
    input  lane_pkg::data_t   data1,
    input  lane_pkg::ctrl_t   ctrl0,
    input  lane_pkg::ctrl_t   ctrl1,
    output logic              full0,
    output logic              full1,
    output logic [DEPTH:0]    space0,
    output logic [DEPTH:0]    space1,
    output logic              out_valid,
    output lane_pkg::lane_t   out_lane,
    output lane_pkg::data_t   out_data,
    output lane_pkg::ctrl_t   out_ctrl,
    output lane_pkg::count_t  bad_count
);

    blk_fifo_if #(.DEPTH(DEPTH)) link0_if ();
    blk_fifo_if #(.DEPTH(DEPTH)) link1_if ();

    net_fifo_buf #(
        .DEPTH(DEPTH)
    ) link0_buf (
        .clk      (clk),
        .reset    (reset),
        .wr       (wr0),
        .w_data_d (data0),
        .w_data_c (ctrl0),
        .port     (link0_if.fifo)
    );

    net_fifo_buf #(
        .DEPTH(DEPTH)
    ) link1_buf (
        .clk      (clk),
        .reset    (reset),
        .wr       (wr1),
        .w_data_d (data1),
        .w_data_c (ctrl1),
        .port     (link1_if.fifo)
    );

    block_merger merger (
        .clk       (clk),
        .reset     (reset),
        .lane0     (link0_if.merger),
        .lane1     (link1_if.merger),
        .out_valid (out_valid),
        .out_lane  (out_lane),
        .out_data  (out_data),
        .out_ctrl  (out_ctrl),
        .bad_count (bad_count)
    );

    // Upstream flow control.
    assign full0  = link0_if.full;
    assign full1  = link1_if.full;
    assign space0 = link0_if.space;
    assign space1 = link1_if.space;

endmodule

// File: src/lane_pkg.sv
package lane_pkg;

    // Block field widths.
    localparam int DATA_W  = 64;
    localparam int CTRL_W  = 2;
    localparam int COUNT_W = 16;

    typedef logic [DATA_W-1:0]  data_t;    // Block payload.
    typedef logic [CTRL_W-1:0]  ctrl_t;    // Sync header.
    typedef logic [0:0]         lane_t;    // Lane number.
    typedef logic [COUNT_W-1:0] count_t;   // Error counter.

    // Valid sync header codes. 00 and 11 are illegal.
    localparam ctrl_t SYNC_DATA = 2'b10;
    localparam ctrl_t SYNC_CTRL = 2'b01;

endpackage

// File: src/net_fifo_buf.sv
`timescale 1ns/1ps

module net_fifo_buf #(
    parameter int DEPTH = 5
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr,
    input  lane_pkg::data_t  w_data_d,
    input  lane_pkg::ctrl_t  w_data_c,
    blk_fifo_if.fifo         port
);
    import lane_pkg::*;

    localparam int ENTRIES = 2**DEPTH;

    typedef logic [DEPTH-1:0] ptr_t;
    typedef logic [DEPTH:0]   space_t;

    localparam space_t SPACE_MAX = space_t'(ENTRIES);

    data_t  d_mem [ENTRIES];
    ctrl_t  c_mem [ENTRIES];

    ptr_t   w_ptr;
    ptr_t   r_ptr;
    ptr_t   w_ptr_succ;
    ptr_t   r_ptr_succ;
    ptr_t   w_ptr_next;
    ptr_t   r_ptr_next;
    logic   full_reg;
    logic   empty_reg;
    logic   full_next;
    logic   empty_next;
    space_t space_reg;
    space_t space_next;
    logic   wr_en;
    logic   rd_en;

    // Writes while full and pops while empty are dropped.
    assign wr_en = wr & ~full_reg;
    assign rd_en = port.rd & ~empty_reg;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            d_mem[w_ptr] <= w_data_d;
            c_mem[w_ptr] <= w_data_c;
        end
    end

    // Show-ahead read side.
    assign port.data  = d_mem[r_ptr];
    assign port.ctrl  = c_mem[r_ptr];
    assign port.empty = empty_reg;
    assign port.full  = full_reg;
    assign port.space = space_reg;

    always_comb begin
        w_ptr_succ = w_ptr + 1'b1;
        r_ptr_succ = r_ptr + 1'b1;
        w_ptr_next = w_ptr;
        r_ptr_next = r_ptr;
        full_next  = full_reg;
        empty_next = empty_reg;
        space_next = space_reg;

        if (wr_en) begin
            w_ptr_next = w_ptr_succ;
        end
        if (rd_en) begin
            r_ptr_next = r_ptr_succ;
        end

        case ({wr_en, rd_en})
            2'b10: begin
                empty_next = 1'b0;
                full_next  = (w_ptr_succ == r_ptr);   // Caught up with reader.
                space_next = space_reg - 1'b1;
            end
            2'b01: begin
                full_next  = 1'b0;
                empty_next = (r_ptr_succ == w_ptr);   // Last entry leaves.
                space_next = space_reg + 1'b1;
            end
            default: begin
                // Idle, or write and pop together. Occupancy holds.
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr     <= '0;
            r_ptr     <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
            space_reg <= SPACE_MAX;
        end else begin
            w_ptr     <= w_ptr_next;
            r_ptr     <= r_ptr_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
            space_reg <= space_next;
        end
    end

endmodule

// File: testbench/tb_dual_link_rx.sv
`timescale 1ns/1ps

module tb_dual_link_rx;
    import lane_pkg::*;

    localparam int DEPTH        = 3;
    localparam int ENTRIES      = 2**DEPTH;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 200;

    logic           clk = 1'b0;
    logic           reset;
    logic           wr0;
    logic           wr1;
    data_t          data0;
    data_t          data1;
    ctrl_t          ctrl0;
    ctrl_t          ctrl1;
    logic           full0;
    logic           full1;
    logic [DEPTH:0] space0;
    logic [DEPTH:0] space1;
    logic           out_valid;
    lane_t          out_lane;
    data_t          out_data;
    ctrl_t          out_ctrl;
    count_t         bad_count;

    int seed;

    logic [65:0] q0 [$];    // Model of lane 0 FIFO as {ctrl, data}.
    logic [65:0] q1 [$];
    logic        prio;      // Model round-robin pointer.
    logic        exp_valid;
    lane_t       exp_lane;
    data_t       exp_data;
    ctrl_t       exp_ctrl;
    int          exp_bad;
    int          exp_space0;
    int          exp_space1;

    bit check_en;
    bit seen_full0;
    int value_errors;
    int timeout_errors;
    int other_errors;
    int blocks_checked;

    dual_link_rx #(.DEPTH(DEPTH)) dut (
        .clk       (clk),
        .reset     (reset),
        .wr0       (wr0),
        .wr1       (wr1),
        .data0     (data0),
        .data1     (data1),
        .ctrl0     (ctrl0),
        .ctrl1     (ctrl1),
        .full0     (full0),
        .full1     (full1),
        .space0    (space0),
        .space1    (space1),
        .out_valid (out_valid),
        .out_lane  (out_lane),
        .out_data  (out_data),
        .out_ctrl  (out_ctrl),
        .bad_count (bad_count)
    );

    always #5 clk = ~clk;

    // Result is {good, lane, ctrl, data}. Headers 00 and 11 are bad.
    function automatic logic [67:0] ref_output(input logic lane, input logic [65:0] entry);
        logic good;
        good = (entry[65:64] == 2'b10) || (entry[65:64] == 2'b01);
        return {good, lane, entry};
    endfunction

    function automatic ctrl_t pick_header(input int r);
        case (r & 7)
            0:       return 2'b00;
            1:       return 2'b11;
            2, 3, 4: return 2'b10;
            default: return 2'b01;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic clear_model();
        q0.delete();
        q1.delete();
        prio       = 1'b0;
        exp_valid  = 1'b0;
        exp_bad    = 0;
        exp_space0 = ENTRIES;
        exp_space1 = ENTRIES;
    endtask

    // One clock edge of the expected behavior. Pop first, then the write.
    task automatic step_model();
        logic [65:0] entry;
        logic [67:0] res;
        logic        sel;
        bit          have0;
        bit          have1;
        bit          room0;
        bit          room1;
        have0     = q0.size() != 0;
        have1     = q1.size() != 0;
        room0     = q0.size() < ENTRIES;    // Full is judged before the edge.
        room1     = q1.size() < ENTRIES;
        exp_valid = 1'b0;
        if (have0 || have1) begin
            sel = (have0 && have1) ? prio : !have0;
            if (sel) begin
                entry = q1.pop_front();
            end else begin
                entry = q0.pop_front();
            end
            res = ref_output(sel, entry);
            if (res[67]) begin
                exp_valid = 1'b1;
                exp_lane  = res[66];
                exp_ctrl  = res[65:64];
                exp_data  = res[63:0];
            end else if (exp_bad < 16'hffff) begin
                exp_bad++;
            end
            prio = !sel;
        end
        if (wr0 && room0) begin
            q0.push_back({ctrl0, data0});
        end
        if (wr1 && room1) begin
            q1.push_back({ctrl1, data1});
        end
        exp_space0 = ENTRIES - q0.size();
        exp_space1 = ENTRIES - q1.size();
    endtask

    always @(posedge clk) begin
        if (reset) begin
            clear_model();
        end else begin
            step_model();
        end
    end

    // Compare against the model mid-cycle.
    always @(negedge clk) begin
        if (check_en) begin
            check_value("out_valid", 64'(exp_valid), 64'(out_valid));
            if (exp_valid) begin
                check_value("out_lane", 64'(exp_lane), 64'(out_lane));
                check_value("out_data", exp_data, out_data);
                check_value("out_ctrl", 64'(exp_ctrl), 64'(out_ctrl));
                blocks_checked++;
            end
            check_value("bad_count", 64'(exp_bad), 64'(bad_count));
            check_value("full0", 64'(exp_space0 == 0), 64'(full0));
            check_value("full1", 64'(exp_space1 == 0), 64'(full1));
            check_value("space0", 64'(exp_space0), 64'(space0));
            check_value("space1", 64'(exp_space1), 64'(space1));
            seen_full0 = seen_full0 | full0;
        end
    end

    // Load is the chance of a write per cycle in sixteenths.
    task automatic run_traffic(input int cycles, input int load0, input int load1);
        int i;
        for (i = 0; i < cycles; i++) begin
            wr0   = ($random(seed) & 15) < load0;
            wr1   = ($random(seed) & 15) < load1;
            data0 = {$random(seed), $random(seed)};
            data1 = {$random(seed), $random(seed)};
            ctrl0 = pick_header($random(seed));
            ctrl1 = pick_header($random(seed));
            @(posedge clk);
            #1;
        end
        wr0 = 1'b0;
        wr1 = 1'b0;
    endtask

    task automatic drain_lanes();
        int n;
        n   = 0;
        wr0 = 1'b0;
        wr1 = 1'b0;
        while ((q0.size() != 0 || q1.size() != 0 || out_valid) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout at %0t: the lanes did not drain", $time);
            timeout_errors++;
        end
    endtask

    task automatic measure_latency();
        int edges;
        wr0   = 1'b1;
        data0 = {$random(seed), $random(seed)};
        ctrl0 = 2'b10;
        @(posedge clk);
        #1;
        wr0   = 1'b0;
        edges = 1;
        while (out_valid !== 1'b1 && edges < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (out_valid !== 1'b1) begin
            $display("Timeout at %0t: a single block never reached the output", $time);
            timeout_errors++;
        end else begin
            check_value("out_valid latency", 64'd2, 64'(edges));
        end
    endtask

    initial begin
        seed           = 32'h50ae35f6;
        reset          = 1'b1;
        wr0            = 1'b0;
        wr1            = 1'b0;
        data0          = '0;
        data1          = '0;
        ctrl0          = '0;
        ctrl1          = '0;
        check_en       = 1'b0;
        seen_full0     = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        blocks_checked = 0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("bad_count", 64'd0, 64'(bad_count));
        check_value("full0", 64'd0, 64'(full0));
        check_value("full1", 64'd0, 64'(full1));
        check_value("space0", 64'(ENTRIES), 64'(space0));
        check_value("space1", 64'(ENTRIES), 64'(space1));
        @(posedge clk);
        #1;
        reset    = 1'b0;
        check_en = 1'b1;

        measure_latency();
        drain_lanes();

        run_traffic(400, 11, 11);   // Both lanes mostly busy.
        drain_lanes();

        seen_full0 = 1'b0;
        run_traffic(24, 16, 16);    // Lane 0 burst, lane 1 kept busy.
        assert (seen_full0) else begin
            $display("Lane 0 never reported full during its burst");
            other_errors++;
        end
        drain_lanes();
        check_value("space0", 64'(ENTRIES), 64'(space0));
        check_value("space1", 64'(ENTRIES), 64'(space1));

        run_traffic(200, 4, 3);     // Light load, mostly single lane pops.
        drain_lanes();
        check_value("bad_count", 64'(exp_bad), 64'(bad_count));

        @(negedge clk);
        check_en = 1'b0;
        $display("Errors: %0d value, %0d timeout, %0d other; %0d blocks checked, %0d bad blocks",
                 value_errors, timeout_errors, other_errors, blocks_checked, exp_bad);
        if (value_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
